//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = uart_echo_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fails if any check fails"
	@echo "  clean  remove the build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- design/string_pkg.sv
/*
 * string layer package.
 * line end characters, idle gap and the string assembly / send FSM states.
 */
package string_pkg;

    localparam logic [7:0] CHAR_CR = 8'h0d;    // carriage return.
    localparam logic [7:0] CHAR_LF = 8'h0a;    // line feed.

    // idle char times that close a string.
    localparam int IDLE_CHARS = 2;

    // string assembly.
    typedef enum logic [1:0] {
        STR_EMPTY,        // no bytes yet.
        STR_COLLECTING,   // bytes arriving, idle timer running.
        STR_FINISH        // publish string.
    } str_rx_state_t;

    // string send.
    typedef enum logic [1:0] {
        STR_TX_IDLE,      // nothing to send.
        STR_TX_LOAD,      // hand next byte to serializer.
        STR_TX_WAIT_BYTE  // byte on the line.
    } str_tx_state_t;

endpackage

//--- design/uart_byte_rx.sv
/*
 * uart byte receiver, 8n1.
 * samples each bit at mid-bit and flags frames whose stop bit is low.
 */
module uart_byte_rx #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_err
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + HALF_BIT + 1);
    localparam int IDX_W        = $clog2(uart_pkg::DATA_BITS);

    uart_pkg::rx_state_t state;
    logic [CNT_W-1:0]    cnt;       // clocks within current bit.
    logic [IDX_W-1:0]    bit_idx;   // data bit being received.
    logic                rx_meta;   // first sync stage.
    logic                rx_sync;   // line in clock domain.
    logic                stop_bit;  // stop bit as sampled.
    logic                bit_tick;  // end of a full bit period.
    logic [7:0]          shift;

    assign bit_tick = (cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign rx_byte  = shift;

    // two flop synchronizer, idles high.
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state     <= uart_pkg::RX_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            stop_bit  <= 1'b1;
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_valid  <= 1'b0;  // pulses only.
            frame_err <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync) begin  // falling edge seen as low while idle.
                        state <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    if (cnt == CNT_W'(HALF_BIT - 1)) begin  // mid start bit.
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;  // glitch?
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_tick) begin
                        cnt <= '0;
                        if (bit_idx == IDX_W'(uart_pkg::DATA_BITS - 1)) begin
                            state <= uart_pkg::RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    cnt <= cnt + 1'b1;
                    if (bit_tick) begin
                        stop_bit <= rx_sync;  // mid stop bit.
                    end
                    // half a bit later the stop bit is over.
                    if (cnt == CNT_W'(CLKS_PER_BIT + HALF_BIT - 1)) begin
                        cnt       <= '0;
                        rx_valid  <= stop_bit;
                        frame_err <= !stop_bit;
                        // back to back frame, next start already on the line.
                        state     <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_START;
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // data shift register, lsb arrives first.
    always_ff @(posedge sys_clk) begin
        if (state == uart_pkg::RX_DATA && bit_tick) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

endmodule

//--- design/uart_byte_tx.sv
/*
 * uart byte transmitter, 8n1.
 * sends one byte per tx_start, line idles high.
 */
module uart_byte_tx #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic [7:0] tx_byte,
    input  logic       tx_start,
    output logic       txd,
    output logic       tx_active,
    output logic       byte_done
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);
    localparam int IDX_W        = $clog2(uart_pkg::DATA_BITS);

    uart_pkg::tx_state_t state;
    logic [CNT_W-1:0]    cnt;       // clocks within current bit.
    logic [IDX_W-1:0]    bit_idx;   // data bit on the line.
    logic [7:0]          shift;     // remaining data bits.
    logic                bit_end;

    assign bit_end   = (cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign tx_active = (state != uart_pkg::TX_IDLE);
    assign byte_done = (state == uart_pkg::TX_STOP) && bit_end;  // last stop cycle.

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state   <= uart_pkg::TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    cnt <= '0;
                    txd <= 1'b1;
                    if (tx_start) begin
                        txd   <= 1'b0;  // start bit from next cycle.
                        state <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    cnt <= bit_end ? '0 : cnt + 1'b1;
                    if (bit_end) begin
                        txd     <= shift[0];
                        bit_idx <= '0;
                        state   <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    cnt <= bit_end ? '0 : cnt + 1'b1;
                    if (bit_end) begin
                        if (bit_idx == IDX_W'(uart_pkg::DATA_BITS - 1)) begin
                            txd   <= 1'b1;  // stop bit.
                            state <= uart_pkg::TX_STOP;
                        end else begin
                            txd     <= shift[1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    cnt <= bit_end ? '0 : cnt + 1'b1;
                    if (bit_end) begin
                        state <= uart_pkg::TX_IDLE;
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // load on accept, shift after each data bit.
    always_ff @(posedge sys_clk) begin
        if (state == uart_pkg::TX_IDLE && tx_start) begin
            shift <= tx_byte;
        end else if (state == uart_pkg::TX_DATA && bit_end) begin
            shift <= {1'b1, shift[7:1]};
        end
    end

endmodule

//--- design/uart_echo.sv
/*
 * uart echo top.
 * sends each received string back with cr lf appended,
 * and shows its first byte on uart_rx_data.
 */
module uart_echo #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200,
    parameter int MAX_LEN   = 16
) (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    output logic [7:0] uart_rx_data,
    input  logic       uart_rx_port,
    output logic       uart_tx_port
);

    logic [(MAX_LEN+2)*8-1:0] echo_string;  // one slot, newest wins.
    logic [(MAX_LEN+2)*8-1:0] echo_next;
    logic [7:0]               echo_len;
    logic                     pending;      // echo waiting for the sender.
    logic                     tx_req;
    logic                     tx_busy;

    logic [MAX_LEN*8-1:0]     rx_string;
    logic [7:0]               rx_length;
    logic                     rx_done;

    assign uart_rx_data = rx_string[7:0];
    assign tx_req       = pending && !tx_busy;  // first free cycle.

    // cr lf right after the last byte.
    always_comb begin
        echo_next = {16'h0000, rx_string};
        echo_next[rx_length*8 +: 8]       = string_pkg::CHAR_CR;
        echo_next[(rx_length + 1)*8 +: 8] = string_pkg::CHAR_LF;
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            pending  <= 1'b0;
            echo_len <= '0;
        end else if (rx_done) begin
            pending  <= 1'b1;  // wins over a same-cycle request.
            echo_len <= rx_length + 8'd2;
        end else if (tx_req) begin
            pending  <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rx_done) begin
            echo_string <= echo_next;
        end
    end

    uart_string_handle #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE),
        .MAX_LEN   (MAX_LEN)
    ) u_string_handle (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .tx_string    (echo_string),
        .tx_length    (echo_len),
        .tx_req       (tx_req),
        .tx_busy      (tx_busy),
        .tx_done      (),
        .rx_string    (rx_string),
        .rx_length    (rx_length),
        .rx_busy      (),
        .rx_done      (rx_done),
        .uart_rx_port (uart_rx_port),
        .uart_tx_port (uart_tx_port)
    );

endmodule

//--- design/uart_pkg.sv
/*
 * uart frame package.
 * frame sizes and the bit-level FSM states of the byte receiver and transmitter.
 */
package uart_pkg;

    // 8n1 framing.
    localparam int DATA_BITS  = 8;                 // payload bits per frame.
    localparam int FRAME_BITS = DATA_BITS + 2;     // start + data + stop.

    // receiver bit FSM.
    typedef enum logic [1:0] {
        RX_IDLE,    // line high, waiting for start.
        RX_START,   // confirming start at mid-bit.
        RX_DATA,    // shifting data bits in, lsb first.
        RX_STOP     // checking stop bit.
    } rx_state_t;

    // transmitter bit FSM.
    typedef enum logic [1:0] {
        TX_IDLE,    // line held high.
        TX_START,   // driving start bit low.
        TX_DATA,    // driving data bits, lsb first.
        TX_STOP     // driving stop bit high.
    } tx_state_t;

endpackage

//--- design/uart_string_handle.sv
/*
 * uart string handler.
 * gathers received bytes into strings closed by an idle gap,
 * and walks a stored string through the byte transmitter.
 */
module uart_string_handle #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200,
    parameter int MAX_LEN   = 16
) (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,

    input  logic [(MAX_LEN+2)*8-1:0]   tx_string,
    input  logic [7:0]                 tx_length,
    input  logic                       tx_req,
    output logic                       tx_busy,
    output logic                       tx_done,

    output logic [MAX_LEN*8-1:0]       rx_string,
    output logic [7:0]                 rx_length,
    output logic                       rx_busy,
    output logic                       rx_done,

    input  logic                       uart_rx_port,
    output logic                       uart_tx_port
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int IDLE_CLKS    = string_pkg::IDLE_CHARS * uart_pkg::FRAME_BITS * CLKS_PER_BIT;
    localparam int IDLE_W       = $clog2(IDLE_CLKS + 1);

    // byte level links.
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       frame_err;
    logic [7:0] byte_data;
    logic       byte_start;
    logic       byte_active;
    logic       byte_done;

    // receive side.
    string_pkg::str_rx_state_t rx_state;
    logic [MAX_LEN*8-1:0]      rx_buf;    // string being assembled.
    logic [7:0]                rx_len;    // bytes stored, capped.
    logic [IDLE_W-1:0]         idle_cnt;  // clocks since last byte.

    // send side.
    string_pkg::str_tx_state_t tx_state;
    logic [(MAX_LEN+2)*8-1:0]  tx_buf;
    logic [7:0]                tx_len;
    logic [7:0]                tx_idx;    // next byte to send.

    assign rx_busy = (rx_state == string_pkg::STR_COLLECTING);
    assign tx_busy = (tx_state != string_pkg::STR_TX_IDLE);

    // serializer fetches straight from the send buffer.
    assign byte_start = (tx_state == string_pkg::STR_TX_LOAD) && !byte_active;
    assign byte_data  = tx_buf[tx_idx*8 +: 8];

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rx_state  <= string_pkg::STR_EMPTY;
            rx_len    <= '0;
            idle_cnt  <= '0;
            rx_done   <= 1'b0;
            rx_string <= '0;
            rx_length <= '0;
        end else begin
            rx_done <= 1'b0;
            case (rx_state)
                string_pkg::STR_EMPTY: begin
                    idle_cnt <= '0;
                    if (rx_valid) begin  // first byte opens a string.
                        rx_len   <= 8'd1;
                        rx_state <= string_pkg::STR_COLLECTING;
                    end
                end
                string_pkg::STR_COLLECTING: begin
                    if (rx_valid || frame_err) begin
                        idle_cnt <= '0;  // line still busy.
                        if (rx_valid && rx_len < 8'(MAX_LEN)) begin
                            rx_len <= rx_len + 1'b1;
                        end
                    end else if (idle_cnt == IDLE_W'(IDLE_CLKS - 1)) begin
                        rx_state <= string_pkg::STR_FINISH;  // gap long enough.
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end
                string_pkg::STR_FINISH: begin
                    rx_string <= rx_buf;  // held until the next string.
                    rx_length <= rx_len;
                    rx_done   <= 1'b1;
                    idle_cnt  <= '0;
                    if (rx_valid) begin  // late byte starts the next string.
                        rx_len   <= 8'd1;
                        rx_state <= string_pkg::STR_COLLECTING;
                    end else begin
                        rx_len   <= '0;
                        rx_state <= string_pkg::STR_EMPTY;
                    end
                end
                default: rx_state <= string_pkg::STR_EMPTY;
            endcase
        end
    end

    // byte store, overflow bytes dropped.
    always_ff @(posedge sys_clk) begin
        if (rx_valid) begin
            if (rx_state == string_pkg::STR_COLLECTING) begin
                if (rx_len < 8'(MAX_LEN)) begin
                    rx_buf[rx_len*8 +: 8] <= rx_byte;
                end
            end else begin
                rx_buf[7:0] <= rx_byte;  // empty or finishing, goes to slot 0.
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            tx_state <= string_pkg::STR_TX_IDLE;
            tx_len   <= '0;
            tx_idx   <= '0;
            tx_done  <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (tx_state)
                string_pkg::STR_TX_IDLE: begin
                    if (tx_req) begin
                        tx_len <= tx_length;
                        tx_idx <= '0;
                        if (tx_length == 8'd0) begin
                            tx_done <= 1'b1;  // nothing to send.
                        end else begin
                            tx_state <= string_pkg::STR_TX_LOAD;
                        end
                    end
                end
                string_pkg::STR_TX_LOAD: begin
                    if (byte_start) begin  // serializer took the byte.
                        tx_idx   <= tx_idx + 1'b1;
                        tx_state <= string_pkg::STR_TX_WAIT_BYTE;
                    end
                end
                string_pkg::STR_TX_WAIT_BYTE: begin
                    if (byte_done) begin
                        if (tx_idx == tx_len) begin
                            tx_done  <= 1'b1;  // last stop bit done.
                            tx_state <= string_pkg::STR_TX_IDLE;
                        end else begin
                            tx_state <= string_pkg::STR_TX_LOAD;
                        end
                    end
                end
                default: tx_state <= string_pkg::STR_TX_IDLE;
            endcase
        end
    end

    // send buffer, copied only while idle.
    always_ff @(posedge sys_clk) begin
        if (tx_req && tx_state == string_pkg::STR_TX_IDLE) begin
            tx_buf <= tx_string;
        end
    end

    uart_byte_rx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_byte_rx (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rxd       (uart_rx_port),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .frame_err (frame_err)
    );

    uart_byte_tx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_byte_tx (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tx_byte   (byte_data),
        .tx_start  (byte_start),
        .txd       (uart_tx_port),
        .tx_active (byte_active),
        .byte_done (byte_done)
    );

endmodule

//--- sources.f
design/uart_pkg.sv
design/string_pkg.sv
design/uart_byte_rx.sv
design/uart_byte_tx.sv
design/uart_string_handle.sv
design/uart_echo.sv
verification/tb_clock.sv
verification/uart_echo_tb.sv

//--- verification/echo_tests.txt
# columns: mode (normal, framing, long), byte count, index of the byte sent with a low
# stop bit (-1 for none), then the bytes in hex. long strings exceed the 16 byte buffer.
normal 1 -1 41
normal 5 -1 48 65 6c 6c 6f
normal 3 -1 00 ff 55
normal 1 -1 7e
framing 4 2 31 32 33 34
normal 2 -1 0d 0a
long 20 -1 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 74
normal 16 -1 30 31 32 33 34 35 36 37 38 39 41 42 43 44 45 46
framing 3 2 61 62 63
normal 1 -1 80
framing 5 1 a5 5a c3 3c 99
long 18 -1 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12
normal 4 -1 de ad be ef
normal 1 -1 20
framing 2 0 f0 0f
normal 8 -1 55 aa 55 aa 01 02 04 08
long 17 -1 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50 51
normal 1 -1 00

//--- verification/tb_clock.sv
/*
 * testbench clock source.
 * free running, starts low.
 */
module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic sys_clk
);

    initial sys_clk = 1'b0;

    always #(PERIOD / 2) sys_clk = ~sys_clk;  // half period per phase.

endmodule

//--- verification/uart_echo_tb.sv
/*
 * uart echo testbench.
 * plays serial strings from the test file into the dut,
 * decodes the echo on the tx line and checks it byte by byte.
 */
module uart_echo_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int CLK_FREQ     = 8;
    localparam int BAUD_RATE    = 1;
    localparam int MAX_LEN      = 16;
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;             // start, 8 data, stop.
    localparam int IDLE_CLKS    = 2 * FRAME_CLKS;                // gap that closes a string.
    localparam int FIRST_WAIT   = IDLE_CLKS + 6 * CLKS_PER_BIT;  // string end to echo start.
    localparam int NEXT_WAIT    = 2 * CLKS_PER_BIT;              // echo bytes back to back.
    localparam int RESET_CYCLES = 3;
    localparam logic [7:0] CHAR_CR = 8'h0d;
    localparam logic [7:0] CHAR_LF = 8'h0a;

    logic       sys_clk;
    logic       sys_rst_n;
    logic       uart_rx_port;
    logic       uart_tx_port;
    logic [7:0] uart_rx_data;

    // tests from the file, all bytes packed back to back.
    logic [7:0] stim_q[$];
    int         first_q[$];   // index of a test's first byte.
    int         count_q[$];
    int         mark_q[$];    // byte with a low stop bit, -1 if none.
    bit         tests_loaded;
    longint     watchdog_limit;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("FAILED at time %0t: %s got %0h, expected %0h",
                               $time, name, got, expected));
        end
    endtask

    task automatic load_tests;
        int               fd;
        int               code;
        int               count;
        int               mark;
        int               i;
        logic [7:0]       value;
        logic [63:0]      word;  // mode word or comment marker.
        logic [8*160-1:0] rest;
        fd = $fopen("verification/echo_tests.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open verification/echo_tests.txt");
        end
        code = $fscanf(fd, "%s", word);
        while (code == 1) begin
            if (word == "#") begin
                code = $fgets(rest, fd);  // rest of a comment line.
            end else begin
                code = $fscanf(fd, "%d %d", count, mark);
                if (code != 2 || count < 1) begin
                    fail_run("malformed line in the test file");
                end
                if (word == "framing") begin
                    if (mark < 0 || mark >= count) begin
                        fail_run("framing test marks no byte of its string");
                    end
                end else if (word == "long") begin
                    if (count <= MAX_LEN || mark != -1) begin
                        fail_run("long test is not longer than the buffer");
                    end
                end else if (word != "normal" || mark != -1) begin
                    fail_run("unknown mode word or stray mark in the test file");
                end
                first_q.push_back(stim_q.size());
                count_q.push_back(count);
                mark_q.push_back(mark);
                for (i = 0; i < count; i++) begin
                    if ($fscanf(fd, "%h", value) != 1) begin
                        fail_run("test file ends inside a byte list");
                    end
                    stim_q.push_back(value);
                end
            end
            code = $fscanf(fd, "%s", word);
        end
        $fclose(fd);
    endtask

    // drive the rx line for a number of clocks, changed on a rising edge.
    task automatic hold_line(input logic level, input int cycles);
        if (cycles > 0) begin
            @(posedge sys_clk);
            uart_rx_port <= level;
            repeat (cycles - 1) @(posedge sys_clk);
        end
    endtask

    task automatic send_byte(input logic [7:0] value, input logic stop_level, input int gap);
        int i;
        hold_line(1'b0, CLKS_PER_BIT);  // start bit.
        for (i = 0; i < 8; i++) begin
            hold_line(value[i], CLKS_PER_BIT);  // lsb first.
        end
        hold_line(stop_level, CLKS_PER_BIT);  // low marks a bad frame.
        hold_line(1'b1, gap);
    endtask

    // decode one echoed byte, sampled on falling edges.
    task automatic receive_byte(input int wait_limit, input int index, output logic [7:0] value);
        int waited;
        int i;
        waited = 0;
        @(negedge sys_clk);
        while (uart_tx_port !== 1'b0 && waited < wait_limit) begin
            @(negedge sys_clk);
            waited++;
        end
        if (uart_tx_port !== 1'b0) begin
            fail_run($sformatf("echo byte %0d never arrived on the tx line", index));
        end
        repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);  // middle of the start bit.
        if (uart_tx_port !== 1'b0) begin
            fail_run($sformatf("start bit of echo byte %0d did not stay low", index));
        end
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge sys_clk);
            value[i] = uart_tx_port;
        end
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        if (uart_tx_port !== 1'b1) begin
            fail_run($sformatf("stop bit of echo byte %0d is not high", index));
        end
    endtask

    // nothing may follow the line feed.
    task automatic check_quiet_line;
        repeat (IDLE_CLKS) begin
            @(negedge sys_clk);
            if (uart_tx_port !== 1'b1) begin
                fail_run("extra data on the tx line after the echo");
            end
        end
    endtask

    task automatic check_after_reset;
        repeat (FRAME_CLKS) begin
            @(negedge sys_clk);
            check_value("uart_tx_port", uart_tx_port, 1);
            check_value("uart_rx_data", uart_rx_data, 0);
        end
    endtask

    task automatic run_test(input int t);
        logic [7:0] expected[$];
        logic [7:0] got;
        int         first;
        int         count;
        int         mark;
        int         gap;
        int         i;
        first = first_q[t];
        count = count_q[t];
        mark  = mark_q[t];
        // bad frames vanish, the rest is cut at the buffer depth.
        for (i = 0; i < count; i++) begin
            if (i != mark && expected.size() < MAX_LEN) begin
                expected.push_back(stim_q[first + i]);
            end
        end
        expected.push_back(CHAR_CR);
        expected.push_back(CHAR_LF);
        for (i = 0; i < count; i++) begin
            gap = $urandom % 4;  // 0 to 3 extra idle clocks.
            send_byte(stim_q[first + i], i != mark, gap);
        end
        hold_line(1'b1, CLKS_PER_BIT);
        if (t == 0) begin
            @(negedge sys_clk);  // string still open, nothing shown yet.
            check_value("uart_rx_data", uart_rx_data, 0);
            check_value("uart_tx_port", uart_tx_port, 1);
        end
        for (i = 0; i < expected.size(); i++) begin
            receive_byte(i == 0 ? FIRST_WAIT : NEXT_WAIT, i, got);
            check_value($sformatf("echo byte %0d of test %0d", i, t), got, expected[i]);
        end
        check_quiet_line();
        check_value("uart_rx_data", uart_rx_data, expected[0]);
    endtask

    tb_clock #(
        .PERIOD (CLK_PERIOD)
    ) u_clock (
        .sys_clk (sys_clk)
    );

    uart_echo #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE),
        .MAX_LEN   (MAX_LEN)
    ) dut (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .uart_rx_data (uart_rx_data),
        .uart_rx_port (uart_rx_port),
        .uart_tx_port (uart_tx_port)
    );

    // budget per test covers a full buffer plus cr lf and the gaps, doubled.
    initial begin
        wait (tests_loaded);
        #(watchdog_limit);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        int t;
        sys_rst_n    <= 1'b0;
        uart_rx_port <= 1'b1;  // line idles high.
        void'($urandom(63258));
        load_tests();
        if (count_q.size() == 0) begin
            fail_run("test file holds no tests");
        end
        watchdog_limit = longint'(count_q.size()) * (MAX_LEN + 4) * FRAME_CLKS
                         * CLK_PERIOD * 2;
        tests_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        check_after_reset();
        for (t = 0; t < count_q.size(); t++) begin
            run_test(t);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
